/* Bender.yml */
package:
  name: quan_mac_row

sources:
  - src/quan_mac_pkg.sv
  - src/mac_if.sv
  - src/operand_packer.sv
  - src/dsp_mult_s25_s18.sv
  - src/packed_accumulator.sv
  - src/quan_mac_pe.sv
  - src/quan_mac_row.sv
  - target: test
    files:
      - tests/quan_mac_row_tb.sv

/* src/dsp_mult_s25_s18.sv */
// signed 25x18 multiply, A/B regs + P reg as in a DSP slice
module dsp_mult_s25_s18 (
  input  logic                                   clk,
  input  logic signed [quan_mac_pkg::OPA_W-1:0]  op_a,
  input  logic signed [quan_mac_pkg::OPB_W-1:0]  op_b,
  output logic signed [quan_mac_pkg::PROD_W-1:0] prod
);
  import quan_mac_pkg::*;

  logic signed [OPA_W-1:0] a_q;  // AREG
  logic signed [OPB_W-1:0] b_q;  // BREG

  ////////////////////
  // stage 1, operand regs
  ////////////////////

  always_ff @(posedge clk) begin
    a_q <= op_a;
    b_q <= op_b;
  end

  ////////////////////
  // stage 2, product reg
  ////////////////////

  // full 43b product, no rounding
  always_ff @(posedge clk) begin
    prod <= a_q * b_q;
  end

endmodule

/* src/mac_if.sv */
// product plus its controls, all from the same sample
interface mac_if;
  import quan_mac_pkg::*;

  logic signed [PROD_W-1:0] prod;  // packed dsp product
  logic [MODE_W-1:0] mode;         // mode the operands were packed with
  logic valid;                     // accumulate this sample
  logic clear;                     // first sample of a new sum

  // multiplier + control delay line
  modport src (output prod, output mode, output valid, output clear);

  // accumulator, read only
  modport dst (input prod, input mode, input valid, input clear);

endinterface

/* src/operand_packer.sv */
module operand_packer (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [quan_mac_pkg::ACT_W-1:0]        act,
  input  logic [quan_mac_pkg::WGT_W-1:0]        weight,
  input  logic [quan_mac_pkg::MODE_W-1:0]       mode,
  output logic signed [quan_mac_pkg::OPA_W-1:0] op_a,
  output logic signed [quan_mac_pkg::OPB_W-1:0] op_b
);
  import quan_mac_pkg::*;

  logic signed [7:0] a0, a1, w;       // int8 fields
  logic signed [3:0] x0, x1, y0, y1;  // int4 fields
  logic signed [OPA_W-1:0] op_a_d;
  logic signed [OPB_W-1:0] op_b_d;

  assign a0 = act[7:0];
  assign a1 = act[15:8];
  assign w  = weight[7:0];  // weight[15:8] unused

  assign x0 = act[3:0];
  assign x1 = act[7:4];
  assign y0 = weight[3:0];
  assign y1 = weight[7:4];

  always_comb begin
    op_a_d = '0;  // unknown mode -> zero product
    op_b_d = '0;
    case (mode)
      MODE_INT8: begin
        // a0*w lands in 15:0, a1*w in 31:16
        op_a_d = OPA_W'(a0) + (OPA_W'(a1) <<< 16);
        op_b_d = OPB_W'(w);
      end
      MODE_INT4: begin
        // 9b fields at 0, 9, 18, 27
        op_a_d = OPA_W'(y0) + (OPA_W'(y1) <<< 18);
        op_b_d = OPB_W'(x0) + (OPB_W'(x1) <<< 9);
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      op_a <= '0;
      op_b <= '0;
    end else begin
      op_a <= op_a_d;
      op_b <= op_b_d;
    end
  end

  // a floating mode would pack garbage into every later sum
  assert property (@(posedge clk) disable iff (reset) !$isunknown(mode))
    else $error("operand_packer: mode has X or Z bits");

endmodule

/* src/packed_accumulator.sv */
module packed_accumulator (
  input  logic                    clk,
  input  logic                    reset,
  mac_if.dst                      mac,
  output quan_mac_pkg::acc_word_u acc,
  output logic                    acc_valid
);
  import quan_mac_pkg::*;

  logic [PROD_W-1:0] p;
  logic [1:0][LANE8_W-1:0] term8;  // int8 lane increments
  logic [3:0][LANE4_W-1:0] term4;  // int4 lane increments
  logic [3:0] carry4;              // sign of the field below
  logic mode_ok;
  acc_word_u acc_d;

  assign p = mac.prod;
  assign mode_ok = (mac.mode == MODE_INT8) || (mac.mode == MODE_INT4);

  ////////////////////
  // split product into lanes
  ////////////////////

  // a negative a0*w borrows one from 31:16 and p[15] gives it back
  assign term8[0] = LANE8_W'($signed(p[15:0]));
  assign term8[1] = LANE8_W'($signed(p[31:16])) + LANE8_W'(p[15]);

  // same fix per 9b field
  assign carry4 = {p[26], p[17], p[8], 1'b0};

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      term4[i] = LANE4_W'($signed(p[9*i +: 9])) + LANE4_W'(carry4[i]);
    end
  end

  ////////////////////
  // lane update
  ////////////////////

  always_comb begin
    acc_d = acc;  // hold by default
    if (mac.valid) begin
      case (mac.mode)
        MODE_INT8: begin
          acc_d.i8.pad = '0;
          for (int i = 0; i < 2; i++) begin
            acc_d.i8.lane[i] = (mac.clear ? '0 : acc.i8.lane[i]) + term8[i];
          end
        end
        MODE_INT4: begin
          for (int i = 0; i < 4; i++) begin
            acc_d.i4.lane[i] = (mac.clear ? '0 : acc.i4.lane[i]) + term4[i];
          end
        end
        default: ;  // unsupported code holds the word
      endcase
    end else if (mac.clear) begin
      acc_d = '0;  // bare clear empties the word
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      acc       <= '0;
      acc_valid <= 1'b0;
    end else begin
      acc       <= acc_d;
      acc_valid <= mac.valid && mode_ok;  // held samples don't report
    end
  end

  // supported code expected on every valid sample
  assert property (@(posedge clk) disable iff (reset)
    mac.valid |-> mode_ok)
    else $warning("packed_accumulator: valid sample with mode %0d ignored", mac.mode);

  // int8 product has only sign bits above lane1's field
  assert property (@(posedge clk) disable iff (reset)
    (mac.valid && mac.mode == MODE_INT8) |->
      ((p[PROD_W-1:31] == '0) || (p[PROD_W-1:31] == '1)))
    else $error("packed_accumulator: int8 product spills above bit 31");

endmodule

/* src/quan_mac_pe.sv */
module quan_mac_pe (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [quan_mac_pkg::ACT_W-1:0]    act,
  input  logic [quan_mac_pkg::WGT_W-1:0]    weight,
  input  logic [quan_mac_pkg::MODE_W-1:0]   mode,
  input  logic                              valid,
  input  logic                              clear,
  output logic [quan_mac_pkg::ACC_W-1:0]    acc,
  output logic                              acc_valid
);
  import quan_mac_pkg::*;

  logic signed [OPA_W-1:0] op_a;
  logic signed [OPB_W-1:0] op_b;

  // control shift regs, [0] is the newest sample
  logic [CTRL_DLY-1:0][MODE_W-1:0] mode_sr;
  logic [CTRL_DLY-1:0] valid_sr;
  logic [CTRL_DLY-1:0] clear_sr;

  mac_if mac_bus ();

  ////////////////////
  // datapath
  ////////////////////

  operand_packer i_packer (
    .clk    (clk),
    .reset  (reset),
    .act    (act),
    .weight (weight),
    .mode   (mode),
    .op_a   (op_a),
    .op_b   (op_b)
  );

  dsp_mult_s25_s18 i_mult (
    .clk  (clk),
    .op_a (op_a),
    .op_b (op_b),
    .prod (mac_bus.prod)  // lands with the 3rd control stage
  );

  ////////////////////
  // control delay, packer + MULT_LAT
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      mode_sr  <= '0;
      valid_sr <= '0;
      clear_sr <= '0;
    end else begin
      mode_sr  <= {mode_sr[CTRL_DLY-2:0], mode};
      valid_sr <= {valid_sr[CTRL_DLY-2:0], valid};
      clear_sr <= {clear_sr[CTRL_DLY-2:0], clear};
    end
  end

  assign mac_bus.mode  = mode_sr[CTRL_DLY-1];
  assign mac_bus.valid = valid_sr[CTRL_DLY-1];
  assign mac_bus.clear = clear_sr[CTRL_DLY-1];

  packed_accumulator i_acc (
    .clk       (clk),
    .reset     (reset),
    .mac       (mac_bus),
    .acc       (acc),
    .acc_valid (acc_valid)
  );

endmodule

/* src/quan_mac_pkg.sv */
package quan_mac_pkg;

  ////////////////////
  // mode codes
  ////////////////////

  localparam int MODE_W = 2;
  localparam logic [MODE_W-1:0] MODE_INT8 = 2'd0;  // a0,a1 x w, two 24b lanes
  localparam logic [MODE_W-1:0] MODE_INT4 = 2'd1;  // x0,x1 x y0,y1, four 16b lanes

  ////////////////////
  // operand and product widths
  ////////////////////

  localparam int ACT_W = 16;  // int8: a1|a0, int4: x1|x0 in bits 7:0
  localparam int WGT_W = 16;  // int8: w in 7:0, int4: y1|y0 in 7:0

  // dsp slice ports
  localparam int OPA_W  = 25;
  localparam int OPB_W  = 18;
  localparam int PROD_W = OPA_W + OPB_W;  // 43

  localparam int MULT_LAT = 2;  // input regs + product reg

  // controls ride along with the packer stage plus the multiplier
  localparam int CTRL_DLY = 1 + MULT_LAT;

  ////////////////////
  // accumulator word
  ////////////////////

  localparam int LANE8_W = 16 + 8;  // 16b product, 8b headroom
  localparam int LANE4_W = 8 + 8;   // 8b product, 8b headroom
  localparam int ACC_W   = 64;

  // one stored word, read per mode
  typedef union packed {
    struct packed {
      logic [ACC_W-2*LANE8_W-1:0] pad;  // unused in int8, kept zero
      logic [1:0][LANE8_W-1:0] lane;    // lane[0] = sum a0*w
    } i8;
    struct packed {
      // lane[0] x0y0, [1] x1y0, [2] x0y1, [3] x1y1
      logic [3:0][LANE4_W-1:0] lane;
    } i4;
  } acc_word_u;

endpackage

/* src/quan_mac_row.sv */
// two PEs, one weight word shared, one activation word each
module quan_mac_row (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [quan_mac_pkg::ACT_W-1:0]  act0,
  input  logic [quan_mac_pkg::ACT_W-1:0]  act1,
  input  logic [quan_mac_pkg::WGT_W-1:0]  weight,
  input  logic [quan_mac_pkg::MODE_W-1:0] mode,
  input  logic                            valid,
  input  logic                            clear,
  output logic [quan_mac_pkg::ACC_W-1:0]  acc0,
  output logic [quan_mac_pkg::ACC_W-1:0]  acc1,
  output logic                            out_valid
);

  ////////////////////
  // element 0
  ////////////////////

  quan_mac_pe i_pe0 (
    .clk       (clk),
    .reset     (reset),
    .act       (act0),
    .weight    (weight),
    .mode      (mode),
    .valid     (valid),
    .clear     (clear),
    .acc       (acc0),
    .acc_valid (out_valid)  // both PEs run in lockstep
  );

  ////////////////////
  // element 1
  ////////////////////

  quan_mac_pe i_pe1 (
    .clk       (clk),
    .reset     (reset),
    .act       (act1),
    .weight    (weight),
    .mode      (mode),
    .valid     (valid),
    .clear     (clear),
    .acc       (acc1),
    .acc_valid ()  // same as pe0
  );

endmodule

/* tb.f */
src/quan_mac_pkg.sv
src/mac_if.sv
src/operand_packer.sv
src/dsp_mult_s25_s18.sv
src/packed_accumulator.sv
src/quan_mac_pe.sv
src/quan_mac_row.sv
tests/quan_mac_row_tb.sv

/* tests/quan_mac_row_tb.sv */
module quan_mac_row_tb;
  import quan_mac_pkg::*;

  localparam int N_RANDOM = 40;
  localparam int DUT_LAT  = 4;  // drive edge to visible acc

  logic clk;
  logic reset;
  logic [ACT_W-1:0] act0, act1;
  logic [WGT_W-1:0] weight;
  logic [MODE_W-1:0] mode;
  logic valid, clear;
  logic [ACC_W-1:0] acc0, acc1;
  logic out_valid;

  // stimulus table, one entry per clock
  logic [MODE_W-1:0] row_mode[$];
  logic row_valid[$];
  logic row_clear[$];
  logic [ACT_W-1:0] row_act0[$];
  logic [ACT_W-1:0] row_act1[$];
  logic [WGT_W-1:0] row_wgt[$];

  // expected outputs, DUT_LAT entries ahead of the DUT
  logic [ACC_W-1:0] exp0_q[$];
  logic [ACC_W-1:0] exp1_q[$];
  logic expv_q[$];

  acc_word_u model0, model1;  // reference lane sums per PE
  int errors = 0;
  int cycles = 0;
  int cycle_limit = 0;
  int seed = 32'hda73_56ff;

  quan_mac_row i_dut (
    .clk       (clk),
    .reset     (reset),
    .act0      (act0),
    .act1      (act1),
    .weight    (weight),
    .mode      (mode),
    .valid     (valid),
    .clear     (clear),
    .acc0      (acc0),
    .acc1      (acc1),
    .out_valid (out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // watchdog
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: run went past %0d cycles without finishing", cycle_limit);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  task automatic add_row(input logic [MODE_W-1:0] m, input logic v, input logic c,
                         input logic [ACT_W-1:0] a0, input logic [ACT_W-1:0] a1,
                         input logic [WGT_W-1:0] w);
    row_mode.push_back(m);
    row_valid.push_back(v);
    row_clear.push_back(c);
    row_act0.push_back(a0);
    row_act1.push_back(a1);
    row_wgt.push_back(w);
  endtask

  task automatic check_value(input string name, input logic [ACC_W-1:0] got,
                             input logic [ACC_W-1:0] exp);
    if (got !== exp) begin
      errors = errors + 1;
      $display("** Error: %s expected 0x%0h, got 0x%0h", name, exp, got);
      $display("ERRORS FOUND");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // one sample applied to a lane word, using true signed products
  function automatic acc_word_u model_step(input acc_word_u cur, input logic [MODE_W-1:0] m,
                                           input logic v, input logic c,
                                           input logic [ACT_W-1:0] act,
                                           input logic [WGT_W-1:0] wgt);
    acc_word_u nxt;
    int a0, a1, w, x0, x1, y0, y1;
    nxt = cur;
    a0 = $signed(act[7:0]);
    a1 = $signed(act[15:8]);
    w  = $signed(wgt[7:0]);
    x0 = $signed(act[3:0]);
    x1 = $signed(act[7:4]);
    y0 = $signed(wgt[3:0]);
    y1 = $signed(wgt[7:4]);
    if (v && m == MODE_INT8) begin
      nxt.i8.pad     = '0;
      nxt.i8.lane[0] = (c ? '0 : cur.i8.lane[0]) + LANE8_W'(a0 * w);
      nxt.i8.lane[1] = (c ? '0 : cur.i8.lane[1]) + LANE8_W'(a1 * w);
    end else if (v && m == MODE_INT4) begin
      nxt.i4.lane[0] = (c ? '0 : cur.i4.lane[0]) + LANE4_W'(x0 * y0);
      nxt.i4.lane[1] = (c ? '0 : cur.i4.lane[1]) + LANE4_W'(x1 * y0);
      nxt.i4.lane[2] = (c ? '0 : cur.i4.lane[2]) + LANE4_W'(x0 * y1);
      nxt.i4.lane[3] = (c ? '0 : cur.i4.lane[3]) + LANE4_W'(x1 * y1);
    end else if (!v && c) begin
      nxt = '0;  // bare clear
    end
    return nxt;
  endfunction

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    logic [31:0] r;
    logic [MODE_W-1:0] rm;
    int i;

    // all inputs idle during reset
    reset  = 1'b1;
    act0   = '0;
    act1   = '0;
    weight = '0;
    mode   = MODE_INT8;
    valid  = 1'b0;
    clear  = 1'b0;
    model0 = '0;
    model1 = '0;

    // idle, then int8 sums with negative a0 for the lane1 carry
    add_row(MODE_INT8, 0, 0, 16'h0000, 16'h0000, 16'h0000);
    add_row(MODE_INT8, 1, 1, 16'h05fd, 16'h8080, 16'h007f);
    add_row(MODE_INT8, 1, 0, 16'hff81, 16'h7f01, 16'h0080);  // w = -128
    add_row(MODE_INT8, 1, 0, 16'h7f80, 16'hc3ff, 16'ha5f3);  // weight[15:8] ignored
    add_row(MODE_INT8, 1, 0, 16'h8080, 16'h8080, 16'h0080);  // -128 x -128
    // held samples, no out_valid
    add_row(MODE_INT8, 0, 0, 16'h1234, 16'h5678, 16'h0011);
    add_row(2'd2,      1, 0, 16'h7f7f, 16'h7f7f, 16'h007f);
    add_row(2'd3,      1, 1, 16'h8181, 16'h0101, 16'h0081);
    add_row(MODE_INT8, 1, 0, 16'h01ff, 16'h02fe, 16'h00fd);
    // int4 extremes
    add_row(MODE_INT4, 1, 1, 16'h0088, 16'h0078, 16'h0088);  // -8 x -8
    add_row(MODE_INT4, 1, 0, 16'hff88, 16'h0087, 16'h0087);  // act[15:8] ignored
    add_row(MODE_INT4, 1, 0, 16'h0077, 16'h00f8, 16'h0078);  // -8 x 7
    add_row(MODE_INT4, 1, 0, 16'h00ff, 16'h0011, 16'h001f);
    add_row(MODE_INT4, 0, 0, 16'h0088, 16'h0088, 16'h0088);
    // back-to-back clears across mode switches
    add_row(MODE_INT8, 1, 1, 16'hfe03, 16'h80ff, 16'h0085);
    add_row(MODE_INT4, 1, 1, 16'h0098, 16'h0089, 16'h0079);
    add_row(MODE_INT8, 1, 1, 16'h7f80, 16'h0180, 16'h007f);
    add_row(MODE_INT8, 1, 0, 16'h8001, 16'hff7f, 16'h00ff);
    add_row(MODE_INT8, 0, 1, 16'h0000, 16'h0000, 16'h0000);  // empties both words
    add_row(MODE_INT4, 1, 0, 16'h0037, 16'h00c9, 16'h00a6);

    // random rows, rare clears and unsupported codes
    for (i = 0; i < N_RANDOM; i++) begin
      r  = $random(seed);
      rm = (r[3:0] == 4'd0) ? 2'd2 : {1'b0, r[4]};
      add_row(rm, r[7:5] != 3'd0, r[11:8] == 4'd0,
              $random(seed), $random(seed), $random(seed));
    end

    cycle_limit = row_mode.size() + 20;

    // reset state visible for the first DUT_LAT cycles
    for (i = 0; i < DUT_LAT; i++) begin
      exp0_q.push_back('0);
      exp1_q.push_back('0);
      expv_q.push_back(1'b0);
    end

    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // table rows, then idle drain
    for (i = 0; i < row_mode.size() + DUT_LAT; i++) begin
      @(posedge clk);
      if (i < row_mode.size()) begin
        mode   <= row_mode[i];
        valid  <= row_valid[i];
        clear  <= row_clear[i];
        act0   <= row_act0[i];
        act1   <= row_act1[i];
        weight <= row_wgt[i];
        model0 = model_step(model0, row_mode[i], row_valid[i], row_clear[i],
                            row_act0[i], row_wgt[i]);
        model1 = model_step(model1, row_mode[i], row_valid[i], row_clear[i],
                            row_act1[i], row_wgt[i]);
        exp0_q.push_back(model0);
        exp1_q.push_back(model1);
        expv_q.push_back(row_valid[i] &&
                         (row_mode[i] == MODE_INT8 || row_mode[i] == MODE_INT4));
      end else begin
        valid <= 1'b0;
        clear <= 1'b0;
      end
      @(negedge clk);  // outputs settled
      check_value("acc0", acc0, exp0_q.pop_front());
      check_value("acc1", acc1, exp1_q.pop_front());
      check_value("out_valid", ACC_W'(out_valid), ACC_W'(expv_q.pop_front()));
    end

    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
